// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = throw_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/hit_collector.sv
`include "throw_consts.svh"

module hit_collector (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear_hits,
    throw_result_if.collector          res [`THROW_LANES],
    output throw_pkg::lane_result_t    results [`THROW_LANES],
    output logic [`THROW_LANES-1:0]    hit
);
    import throw_pkg::*;

    for (genvar i = 0; i < `THROW_LANES; i++) begin : g_lane
        lane_result_t result_q;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                result_q <= '0;
            end else begin
                if (res[i].done) begin
                    result_q.land_x  <= res[i].land_x;
                    result_q.blocked <= res[i].blocked;
                end
                // the count sticks at 255 instead of wrapping.
                if (clear_hits) begin
                    result_q.hits <= '0;
                end else if (res[i].hit && !(&result_q.hits)) begin
                    result_q.hits <= result_q.hits + 8'd1;
                end
            end
        end

        assign results[i] = result_q;
        assign hit[i]     = res[i].hit;
    end

endmodule

// File: logic/throw_apb_regs.sv
`include "throw_consts.svh"

module throw_apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    input  throw_pkg::lane_result_t    results [`THROW_LANES],
    input  logic [`THROW_LANES-1:0]    busy,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       clear_hits,
    throw_cmd_if.feeder                cmd [`THROW_LANES]
);
    import throw_pkg::*;

    localparam int LW = $clog2(`THROW_LANES);
    localparam int TW = $clog2(`THROW_TICK_DIV);

    force_t                  force_q [`THROW_LANES];
    vel_t                    wind_q;
    logic [`THROW_LANES-1:0] launch_q;
    logic [TW-1:0]           tick_cnt;
    logic                    tick_q;
    logic [LW-1:0]           lane_sel;
    logic                    is_force;
    logic                    is_status;
    logic                    mapped;
    logic                    wr_en;

    assign lane_sel  = paddr[LW+1:2];
    assign is_force  = (paddr[1:0] == 2'b00) && (paddr >= `ADDR_FORCE) &&
                       (int'(paddr) < int'(`ADDR_FORCE) + 4 * `THROW_LANES);
    assign is_status = (paddr[1:0] == 2'b00) && (paddr >= `ADDR_STATUS) &&
                       (int'(paddr) < int'(`ADDR_STATUS) + 4 * `THROW_LANES);
    assign mapped    = (paddr == `ADDR_CTRL) || (paddr == `ADDR_WIND) || is_force ||
                       is_status || (paddr == `ADDR_HITS);

    assign wr_en   = psel && penable && pwrite;
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !mapped;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wind_q     <= '0;
            launch_q   <= '0;
            clear_hits <= 1'b0;
            for (int i = 0; i < `THROW_LANES; i++) begin
                force_q[i] <= '0;
            end
        end else begin
            launch_q   <= '0;
            clear_hits <= 1'b0;
            if (wr_en) begin
                if (paddr == `ADDR_CTRL) begin
                    launch_q <= pwdata[`THROW_LANES-1:0];
                end else if (paddr == `ADDR_WIND) begin
                    wind_q <= pwdata[7:0];
                end else if (is_force) begin
                    force_q[lane_sel] <= pwdata[9:0];
                end else if (paddr == `ADDR_HITS) begin
                    clear_hits <= 1'b1;
                end
            end
        end
    end

    // free-running tick shared by every lane.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            tick_q   <= 1'b0;
        end else if (tick_cnt == TW'(`THROW_TICK_DIV - 1)) begin
            tick_cnt <= '0;
            tick_q   <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick_q   <= 1'b0;
        end
    end

    // status layout is busy in bit 31, blocked in bit 16, land_x sign-extended below.
    always_comb begin
        prdata = '0;
        if (paddr == `ADDR_WIND) begin
            prdata = {{24{wind_q[7]}}, wind_q};
        end else if (is_force) begin
            prdata = {22'd0, force_q[lane_sel]};
        end else if (is_status) begin
            prdata = {busy[lane_sel], 14'd0, results[lane_sel].blocked,
                      {4{results[lane_sel].land_x[11]}}, results[lane_sel].land_x};
        end else if (paddr == `ADDR_HITS) begin
            for (int i = 0; i < `THROW_LANES; i++) begin
                prdata[8*i +: 8] = results[i].hits;
            end
        end
    end

    for (genvar i = 0; i < `THROW_LANES; i++) begin : g_cmd
        assign cmd[i].launch      = launch_q[i];
        assign cmd[i].throw_force = force_q[i];
        assign cmd[i].wind        = wind_q;
        assign cmd[i].tick        = tick_q;
    end

endmodule

// File: logic/throw_consts.svh
`ifndef THROW_CONSTS_SVH
`define THROW_CONSTS_SVH

// number of trajectory lanes flying in parallel.
`define THROW_LANES 4
// clock cycles per physics tick.
`define THROW_TICK_DIV 8

// launch point and initial upward speed, in world units.
`define THROW_START_X 140
`define THROW_START_Y 350
`define THROW_INIT_VY 27
`define THROW_GRAVITY 1
`define THROW_FLOOR_Y 0

// the wall box reaches from the floor up to WALL_TOP.
`define THROW_WALL_XL 490
`define THROW_WALL_XR 534
`define THROW_WALL_TOP 241

`define THROW_TGT_XL 600
`define THROW_TGT_XR 760
`define THROW_TGT_YB 0
`define THROW_TGT_YT 100

// horizontal step is force * FORCE_MUL / FORCE_DIV.
`define THROW_FORCE_MUL 18
`define THROW_FORCE_DIV 100

`define ADDR_CTRL 8'h00
`define ADDR_WIND 8'h04
`define ADDR_FORCE 8'h10
`define ADDR_STATUS 8'h20
`define ADDR_HITS 8'h30

`endif

// File: logic/throw_if.sv
interface throw_cmd_if;
    import throw_pkg::*;

    logic   launch;
    force_t throw_force;
    vel_t   wind;
    logic   tick;

    modport feeder (output launch, output throw_force, output wind, output tick);
    modport lane (input launch, input throw_force, input wind, input tick);
endinterface

interface throw_result_if;
    import throw_pkg::*;

    logic   done;
    coord_t land_x;
    logic   blocked;
    logic   hit;

    modport lane (output done, output land_x, output blocked, output hit);
    modport collector (input done, input land_x, input blocked, input hit);
endinterface

// File: logic/throw_pkg.sv
package throw_pkg;

    // world position, positive y points up.
    typedef logic signed [11:0] coord_t;

    // speed per physics tick, also used for the wind.
    typedef logic signed [7:0] vel_t;

    typedef logic [9:0] force_t;

    typedef enum logic [1:0] {
        IDLE,
        FLY,
        DONE
    } lane_state_t;

    // what the collector keeps for one lane.
    typedef struct packed {
        coord_t      land_x;
        logic        blocked;
        logic [7:0]  hits;
    } lane_result_t;

endpackage

// File: logic/throw_top.sv
`include "throw_consts.svh"

module throw_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic [`THROW_LANES-1:0] busy,
    output logic [`THROW_LANES-1:0] hit
);
    import throw_pkg::*;

    lane_result_t results [`THROW_LANES];
    logic         clear_hits;

    throw_cmd_if    cmd_if [`THROW_LANES] ();
    throw_result_if res_if [`THROW_LANES] ();

    throw_apb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .results    (results),
        .busy       (busy),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .clear_hits (clear_hits),
        .cmd        (cmd_if)
    );

    for (genvar i = 0; i < `THROW_LANES; i++) begin : g_lane
        throw_trajectory u_lane (
            .clk  (clk),
            .rst  (rst),
            .cmd  (cmd_if[i]),
            .res  (res_if[i]),
            .busy (busy[i])
        );
    end

    hit_collector u_collect (
        .clk        (clk),
        .rst        (rst),
        .clear_hits (clear_hits),
        .res        (res_if),
        .results    (results),
        .hit        (hit)
    );

endmodule

// File: logic/throw_trajectory.sv
`include "throw_consts.svh"

module throw_trajectory (
    input  logic         clk,
    input  logic         rst,
    throw_cmd_if.lane    cmd,
    throw_result_if.lane res,
    output logic         busy
);
    import throw_pkg::*;

    lane_state_t       state;
    force_t            force_q;
    vel_t              wind_q;
    coord_t            x_q;
    coord_t            y_q;
    vel_t              vy_q;
    coord_t            land_q;
    logic              blocked_q;
    logic              done_q;
    logic              hit_q;
    logic              in_tgt_q;
    logic [14:0]       prod;
    logic [7:0]        step_mag;
    logic signed [9:0] step;
    coord_t            nx;
    coord_t            ny;
    logic              in_wall;
    logic              in_tgt;
    logic              below;
    logic              launch_ok;
    logic              step_en;

    // a running flight cannot be restarted.
    assign launch_ok = cmd.launch && (state != FLY);
    assign step_en   = (state == FLY) && cmd.tick;

    always_comb begin
        prod     = 15'(force_q) * 15'(`THROW_FORCE_MUL);
        step_mag = 8'(prod / 15'(`THROW_FORCE_DIV));
        step     = $signed({2'b00, step_mag}) + 10'(wind_q);
        nx       = x_q + 12'(step);
        ny       = y_q + 12'(vy_q);
        in_wall  = (nx >= `THROW_WALL_XL) && (nx <= `THROW_WALL_XR) &&
                   (ny <= `THROW_WALL_TOP);
        below    = ny < `THROW_FLOOR_Y;
        in_tgt   = (nx >= `THROW_TGT_XL) && (nx <= `THROW_TGT_XR) &&
                   (ny >= `THROW_TGT_YB) && (ny <= `THROW_TGT_YT);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            busy     <= 1'b0;
            done_q   <= 1'b0;
            hit_q    <= 1'b0;
            in_tgt_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            hit_q  <= 1'b0;
            if (launch_ok) begin
                state    <= FLY;
                busy     <= 1'b1;
                in_tgt_q <= 1'b0;
            end else begin
                // busy drops the cycle after done so the collector is already updated.
                if (done_q) begin
                    busy <= 1'b0;
                end
                if (step_en) begin
                    in_tgt_q <= in_tgt;
                    hit_q    <= in_tgt && !in_tgt_q;
                    if (in_wall || below) begin
                        state  <= DONE;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch_ok) begin
            force_q <= cmd.throw_force;
            wind_q  <= cmd.wind;
            x_q     <= coord_t'(`THROW_START_X);
            y_q     <= coord_t'(`THROW_START_Y);
            vy_q    <= vel_t'(`THROW_INIT_VY);
        end else if (step_en) begin
            if (in_wall) begin
                // the projectile stops at its last position in front of the wall.
                land_q    <= x_q;
                blocked_q <= 1'b1;
            end else if (below) begin
                land_q    <= nx;
                blocked_q <= 1'b0;
            end else begin
                x_q  <= nx;
                y_q  <= ny;
                vy_q <= vy_q - vel_t'(`THROW_GRAVITY);
            end
        end
    end

    assign res.done    = done_q;
    assign res.land_x  = land_q;
    assign res.blocked = blocked_q;
    assign res.hit     = hit_q;

endmodule

// File: verification/throw_assertions.sv
`include "throw_consts.svh"

module throw_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    psel,
    input logic                    penable,
    input logic                    pready,
    input logic                    pslverr,
    input logic [`THROW_LANES-1:0] busy,
    input logic [`THROW_LANES-1:0] hit
);
    timeunit 1ns;
    timeprecision 100ps;

    pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an access phase");

    // a lane only reports target entries while it is flying.
    hit_needs_busy: assert property (@(posedge clk) disable iff (rst)
        (hit & ~busy) == '0)
        else $error("hit pulse on a lane that is not busy");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (busy == '0) ##1 (busy == '0))
        else $error("busy rose too early after reset");

endmodule

bind throw_top throw_assertions u_assert (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy),
    .hit     (hit)
);

// File: verification/throw_clk_gen.sv
module throw_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset covers four rising edges and drops on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verification/throw_tb.sv
`include "throw_consts.svh"

module throw_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import throw_pkg::*;

    localparam int TIMEOUT = 2000;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [7:0]              paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic [`THROW_LANES-1:0] busy;
    logic [`THROW_LANES-1:0] hit;

    logic [31:0] rng = 32'h73b9_d781;
    int          checks = 0;
    int          errors = 0;
    int          hit_seen [`THROW_LANES];
    int          exp_hits [`THROW_LANES];
    string       name_q [$];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];

    throw_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    throw_top dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .hit     (hit)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // positions live in a 12-bit signed register and wrap like one.
    function automatic int wrap_coord(input int v);
        coord_t c;
        c = coord_t'(v);
        return int'(c);
    endfunction

    function automatic void flight_ref(input int frc, input int wnd, output int land_x,
                                       output logic blocked, output int entries);
        int   x;
        int   y;
        int   vy;
        int   s;
        int   nx;
        int   ny;
        logic in_t;
        logic prev_t;
        logic done;
        s = (frc * `THROW_FORCE_MUL) / `THROW_FORCE_DIV + wnd;
        x = `THROW_START_X;
        y = `THROW_START_Y;
        vy = `THROW_INIT_VY;
        prev_t = 1'b0;
        done = 1'b0;
        land_x = 0;
        blocked = 1'b0;
        entries = 0;
        for (int t = 0; t < 200 && !done; t++) begin
            nx = wrap_coord(x + s);
            ny = y + vy;
            in_t = (nx >= `THROW_TGT_XL) && (nx <= `THROW_TGT_XR) &&
                   (ny >= `THROW_TGT_YB) && (ny <= `THROW_TGT_YT);
            if (in_t && !prev_t) begin
                entries++;
            end
            prev_t = in_t;
            if (nx >= `THROW_WALL_XL && nx <= `THROW_WALL_XR && ny <= `THROW_WALL_TOP) begin
                land_x = x;
                blocked = 1'b1;
                done = 1'b1;
            end else if (ny < `THROW_FLOOR_Y) begin
                land_x = nx;
                done = 1'b1;
            end else begin
                x = nx;
                y = ny;
                vy = vy - `THROW_GRAVITY;
            end
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    always @(negedge clk) begin
        while (got_q.size() > 0) begin
            compare(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `THROW_LANES; i++) begin
                if (hit[i]) begin
                    hit_seen[i]++;
                end
            end
        end
    end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #10;
        data = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_busy(input logic [`THROW_LANES-1:0] mask, input logic level);
        logic [`THROW_LANES-1:0] target;
        int                      cycles;
        target = level ? mask : '0;
        cycles = 0;
        while ((busy & mask) != target && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if ((busy & mask) != target) begin
            errors++;
            $display("timeout: busy of lanes %b did not go %s within %0d cycles",
                     mask, level ? "high" : "low", TIMEOUT);
        end
    endtask

    task automatic pick_throw(output int frc, output int wnd);
        rng = xorshift(rng);
        frc = int'(rng % 32'd1024);
        rng = xorshift(rng);
        wnd = int'(rng % 32'd41) - 20;
    endtask

    task automatic set_wind(input int wnd);
        apb_write(`ADDR_WIND, 32'(wnd) & 32'h0000_00ff);
    endtask

    task automatic throw_lanes(input logic [`THROW_LANES-1:0] mask);
        apb_write(`ADDR_CTRL, 32'(mask));
        wait_busy(mask, 1'b1);
        wait_busy(mask, 1'b0);
    endtask

    task automatic check_status(input int lane, input int frc, input int wnd,
                                output int entries);
        int          land;
        logic        blk;
        logic [31:0] rd;
        logic        err;
        flight_ref(frc, wnd, land, blk, entries);
        apb_read(8'(`ADDR_STATUS + 4 * lane), rd, err);
        expect_value($sformatf("lane%0d status pslverr", lane), 32'(err), 32'd0);
        expect_value($sformatf("lane%0d busy", lane), 32'(rd[31]), 32'd0);
        expect_value($sformatf("lane%0d blocked", lane), 32'(rd[16]), 32'(blk));
        // land_x reads back sign-extended to 16 bits.
        expect_value($sformatf("lane%0d land_x", lane), 32'(rd[15:0]),
                     32'(land) & 32'h0000_ffff);
    endtask

    task automatic clear_counts();
        apb_write(`ADDR_HITS, 32'd0);
        for (int i = 0; i < `THROW_LANES; i++) begin
            hit_seen[i] = 0;
            exp_hits[i] = 0;
        end
    endtask

    task automatic check_hits();
        logic [31:0] rd;
        logic        err;
        apb_read(`ADDR_HITS, rd, err);
        expect_value("hits pslverr", 32'(err), 32'd0);
        for (int i = 0; i < `THROW_LANES; i++) begin
            expect_value($sformatf("lane%0d hit count", i), 32'(rd[8*i +: 8]), 32'(exp_hits[i]));
            expect_value($sformatf("lane%0d hit pulses", i), 32'(hit_seen[i]),
                         32'(exp_hits[i]));
        end
    endtask

    initial begin
        int          frc [`THROW_LANES];
        int          wnd;
        int          ent;
        int          n;
        logic [31:0] rd;
        logic        err;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'h00;
        pwdata = 32'h0;
        for (int i = 0; i < `THROW_LANES; i++) begin
            hit_seen[i] = 0;
            exp_hits[i] = 0;
        end
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            errors++;
            $display("timeout: reset never released");
        end
        @(negedge clk);

        // quiet state after reset and an unmapped access.
        expect_value("busy", 32'(busy), 32'd0);
        expect_value("hit", 32'(hit), 32'd0);
        for (int i = 0; i < `THROW_LANES; i++) begin
            apb_read(8'(`ADDR_STATUS + 4 * i), rd, err);
            expect_value($sformatf("lane%0d status", i), rd, 32'd0);
        end
        apb_read(`ADDR_HITS, rd, err);
        expect_value("hits", rd, 32'd0);
        apb_read(8'h3c, rd, err);
        expect_value("unmapped pslverr", 32'(err), 32'd1);

        pick_throw(frc[0], wnd);
        set_wind(wnd);
        apb_write(`ADDR_FORCE, 32'(frc[0]));
        throw_lanes(4'b0001);
        check_status(0, frc[0], wnd, ent);

        // all lanes fly at once under one shared wind.
        clear_counts();
        pick_throw(frc[0], wnd);
        for (int i = 1; i < `THROW_LANES; i++) begin
            pick_throw(frc[i], n);
        end
        set_wind(wnd);
        for (int i = 0; i < `THROW_LANES; i++) begin
            apb_write(8'(`ADDR_FORCE + 4 * i), 32'(frc[i]));
        end
        throw_lanes(4'b1111);
        for (int i = 0; i < `THROW_LANES; i++) begin
            check_status(i, frc[i], wnd, ent);
            exp_hits[i] = ent;
        end
        check_hits();

        // a step of 8 per tick passes through the target box.
        clear_counts();
        set_wind(0);
        apb_write(`ADDR_FORCE, 32'd45);
        throw_lanes(4'b0001);
        check_status(0, 45, 0, ent);
        exp_hits[0] = ent;
        check_hits();
        apb_write(`ADDR_HITS, 32'd0);
        apb_read(`ADDR_HITS, rd, err);
        expect_value("hits after clear", rd, 32'd0);

        // a step of 6 meets the wall on the way down.
        apb_write(8'(`ADDR_FORCE + 4), 32'd34);
        throw_lanes(4'b0010);
        check_status(1, 34, 0, ent);

        apb_write(`ADDR_FORCE, 32'd34);
        apb_write(`ADDR_CTRL, 32'd1);
        wait_busy(4'b0001, 1'b1);
        apb_write(`ADDR_FORCE, 32'd45);
        apb_write(`ADDR_CTRL, 32'd1);
        wait_busy(4'b0001, 1'b0);
        check_status(0, 34, 0, ent);

        n = 0;
        while (got_q.size() > 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (got_q.size() > 0) begin
            errors++;
            $display("timeout: %0d comparisons were never made", got_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/throw_pkg.sv
logic/throw_if.sv
logic/throw_apb_regs.sv
logic/throw_trajectory.sv
logic/hit_collector.sv
logic/throw_top.sv
verification/throw_clk_gen.sv
verification/throw_assertions.sv
verification/throw_tb.sv
